/* design/axi2bnk_consts.svh */
`ifndef AXI2BNK_CONSTS_SVH
`define AXI2BNK_CONSTS_SVH

//////////////////////////////
// AXI side widths
//////////////////////////////

// Transaction ID
`define AXI2BNK_ID_W 4

// Byte address, shared with the bank
`define AXI2BNK_ADDR_W 32

// Data beat and its byte strobes
`define AXI2BNK_DATA_W 64
`define AXI2BNK_STRB_W (`AXI2BNK_DATA_W / 8)

//////////////////////////////
// Burst description
//////////////////////////////

// AxLEN, beats minus one
`define AXI2BNK_LEN_W 8

// AxSIZE, log2 of bytes per beat
`define AXI2BNK_SIZE_W 3

`endif

/* design/axi2bnk_pkg.sv */
`include "axi2bnk_consts.svh"

package axi2bnk_pkg;

  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10,
    RSVD  = 2'b11
  } burst_e;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10
  } resp_e;

  typedef enum logic [1:0] {
    INIT_RESET   = 2'b00,
    INIT_PENDING = 2'b01,
    INIT_DONE    = 2'b10
  } init_state_e;

  // One address command as taken from AR or AW
  typedef struct packed {
    logic [`AXI2BNK_ID_W-1:0]   id;
    logic [`AXI2BNK_ADDR_W-1:0] addr;
    logic [`AXI2BNK_LEN_W-1:0]  len;
    logic [`AXI2BNK_SIZE_W-1:0] size;
    burst_e                     burst;
    logic                       lock;
    logic                       ecc_en;
  } axi_cmd_t;

  // Bank command word, init in the top bit
  typedef struct packed {
    logic                       init;
    logic [`AXI2BNK_ID_W-1:0]   id;
    logic                       ecc_en;
    logic                       cmd_err;
    logic [`AXI2BNK_ADDR_W-1:0] addr;
    logic [`AXI2BNK_LEN_W-1:0]  len;
    logic [`AXI2BNK_SIZE_W-1:0] size;
    logic                       wrap;
    logic                       read;
    logic                       excl;
  } bnk_cmd_t;

  typedef struct packed {
    logic [`AXI2BNK_STRB_W-1:0] strb;
    logic [`AXI2BNK_DATA_W-1:0] data;
  } bnk_wr_t;

  typedef struct packed {
    logic [`AXI2BNK_ID_W-1:0]   id;
    logic                       dbe;
    logic                       sbe;
    logic                       last;
    logic                       err;
    logic                       excl_ok;
    logic [`AXI2BNK_DATA_W-1:0] data;
  } bnk_rd_t;

  typedef struct packed {
    logic                     last;
    logic [`AXI2BNK_ID_W-1:0] id;
    logic                     err;
    logic                     excl_ok;
  } bnk_wrsp_t;

endpackage

/* design/cmd_capture.sv */
`timescale 1ns/1ps

module cmd_capture
(
  input  logic                   axi_clk,
  input  logic                   rst_a,
  input  logic                   init_done,
  input  logic                   axi_valid,
  output logic                   axi_ready,
  input  axi2bnk_pkg::axi_cmd_t  axi_cmd,
  input  logic                   ecc_enable,
  output logic                   held_valid,
  output axi2bnk_pkg::axi_cmd_t  held_cmd,
  input  logic                   bnk_accept
);

  logic                  held_q;
  axi2bnk_pkg::axi_cmd_t cap_cmd;

  // Slot is free when empty or when the bank takes the old command now
  assign axi_ready = init_done & (~held_q | bnk_accept);

  // Held command stays parked while an init sequence runs
  assign held_valid = held_q & init_done;

  // ECC enable is sampled with the command, not later
  always_comb
  begin
    cap_cmd        = axi_cmd;
    cap_cmd.ecc_en = ecc_enable;
  end

  //////////////////////////////
  // Holding register
  //////////////////////////////

  always_ff @(posedge axi_clk or posedge rst_a)
  begin : held_flag_proc
    if (rst_a)
    begin
      held_q <= 1'b0;
    end
    else if (axi_ready)
    begin
      held_q <= axi_valid;
    end
  end

  always_ff @(posedge axi_clk)
  begin : held_cmd_proc
    if (axi_valid && axi_ready)
    begin
      held_cmd <= cap_cmd;
    end
  end

endmodule

/* design/cmd_encode.sv */
`timescale 1ns/1ps

module cmd_encode
(
  input  logic                   rd_held_valid,
  input  axi2bnk_pkg::axi_cmd_t  rd_held_cmd,
  output logic                   rd_bnk_accept,
  input  logic                   wr_held_valid,
  input  axi2bnk_pkg::axi_cmd_t  wr_held_cmd,
  output logic                   wr_bnk_accept,
  input  logic                   init_pending,
  output logic                   bnk_rd_cmd_valid,
  output axi2bnk_pkg::bnk_cmd_t  bnk_rd_cmd_data,
  input  logic                   bnk_rd_cmd_accept,
  output logic                   bnk_wr_cmd_valid,
  output axi2bnk_pkg::bnk_cmd_t  bnk_wr_cmd_data,
  input  logic                   bnk_wr_cmd_accept
);

  // Field mapping common to both channels
  function automatic axi2bnk_pkg::bnk_cmd_t encode_cmd(
    input axi2bnk_pkg::axi_cmd_t cmd,
    input logic                  is_read
  );
    axi2bnk_pkg::bnk_cmd_t word;
    word.init    = 1'b0;
    word.id      = cmd.id;
    word.ecc_en  = cmd.ecc_en;
    // Only INCR and WRAP are legal for the bank
    word.cmd_err = (cmd.burst == axi2bnk_pkg::FIXED) || (cmd.burst == axi2bnk_pkg::RSVD);
    word.addr    = cmd.addr;
    word.len     = cmd.len;
    word.size    = cmd.size;
    word.wrap    = (cmd.burst == axi2bnk_pkg::WRAP);
    word.read    = is_read;
    word.excl    = cmd.lock;
    return word;
  endfunction

  //////////////////////////////
  // Read command channel
  //////////////////////////////

  assign bnk_rd_cmd_valid = rd_held_valid;
  assign bnk_rd_cmd_data  = encode_cmd(rd_held_cmd, 1'b1);
  assign rd_bnk_accept    = bnk_rd_cmd_accept;

  //////////////////////////////
  // Write command channel
  //////////////////////////////

  // Init request shares the write command path
  assign bnk_wr_cmd_valid = wr_held_valid | init_pending;

  always_comb
  begin
    bnk_wr_cmd_data = encode_cmd(wr_held_cmd, 1'b0);
    if (init_pending)
    begin
      bnk_wr_cmd_data.init = 1'b1;
      bnk_wr_cmd_data.addr = '0;
    end
  end

  // An accepted init word must not pop the held AW command
  assign wr_bnk_accept = bnk_wr_cmd_accept & ~init_pending;

endmodule

/* design/init_ctrl.sv */
`timescale 1ns/1ps

module init_ctrl
(
  input  logic axi_clk,
  input  logic rst_a,
  input  logic disable_rst_init,
  input  logic init_start,
  input  logic bnk_rd_valid,
  output logic init_done,
  output logic init_pending
);

  axi2bnk_pkg::init_state_e state;
  logic                     init_start_r;
  logic                     init_start_rise;

  assign init_start_rise = init_start & ~init_start_r;

  assign init_done    = (state == axi2bnk_pkg::INIT_DONE);
  assign init_pending = (state == axi2bnk_pkg::INIT_PENDING);

  always_ff @(posedge axi_clk or posedge rst_a)
  begin : init_fsm_proc
    if (rst_a)
    begin
      state        <= axi2bnk_pkg::INIT_RESET;
      init_start_r <= 1'b0;
    end
    else
    begin
      init_start_r <= init_start;
      case (state)
        axi2bnk_pkg::INIT_RESET:
          state <= disable_rst_init ? axi2bnk_pkg::INIT_DONE : axi2bnk_pkg::INIT_PENDING;
        // Bank signals completion with a read word
        axi2bnk_pkg::INIT_PENDING:
          if (bnk_rd_valid)
          begin
            state <= axi2bnk_pkg::INIT_DONE;
          end
        axi2bnk_pkg::INIT_DONE:
          if (init_start_rise)
          begin
            state <= axi2bnk_pkg::INIT_PENDING;
          end
        default:
          state <= axi2bnk_pkg::INIT_RESET;
      endcase
    end
  end

endmodule

/* design/wdata_stage.sv */
`timescale 1ns/1ps
`include "axi2bnk_consts.svh"

module wdata_stage
(
  input  logic                       axi_clk,
  input  logic                       rst_a,
  input  logic                       init_done,
  input  logic                       wvalid,
  output logic                       wready,
  input  logic [`AXI2BNK_DATA_W-1:0] wdata,
  input  logic [`AXI2BNK_STRB_W-1:0] wstrb,
  output logic                       bnk_wr_valid,
  output axi2bnk_pkg::bnk_wr_t       bnk_wr_data,
  input  logic                       bnk_wr_accept
);

  logic held_q;

  // Same one-deep rule as the address channels
  assign wready       = init_done & (~held_q | bnk_wr_accept);
  assign bnk_wr_valid = held_q & init_done;

  //////////////////////////////
  // Beat register
  //////////////////////////////

  always_ff @(posedge axi_clk or posedge rst_a)
  begin : held_flag_proc
    if (rst_a)
    begin
      held_q <= 1'b0;
    end
    else if (wready)
    begin
      held_q <= wvalid;
    end
  end

  // Strobes ride above the data in the bank word
  always_ff @(posedge axi_clk)
  begin : held_beat_proc
    if (wvalid && wready)
    begin
      bnk_wr_data.strb <= wstrb;
      bnk_wr_data.data <= wdata;
    end
  end

endmodule

/* design/bnk_resp_unpack.sv */
`timescale 1ns/1ps
`include "axi2bnk_consts.svh"

module bnk_resp_unpack
(
  input  logic                       axi_clk,
  input  logic                       rst_a,
  input  logic                       init_done,
  input  logic                       bnk_rd_valid,
  input  axi2bnk_pkg::bnk_rd_t       bnk_rd_data,
  output logic                       bnk_rd_accept,
  output logic                       rvalid,
  input  logic                       rready,
  output logic [`AXI2BNK_DATA_W-1:0] rdata,
  output logic                       rlast,
  output axi2bnk_pkg::resp_e         rresp,
  output logic [`AXI2BNK_ID_W-1:0]   rid,
  input  logic                       bnk_rsp_valid,
  input  axi2bnk_pkg::bnk_wrsp_t     bnk_rsp_data,
  output logic                       bnk_rsp_accept,
  output logic                       bvalid,
  input  logic                       bready,
  output axi2bnk_pkg::resp_e         bresp,
  output logic [`AXI2BNK_ID_W-1:0]   bid
);

  logic wr_err_sticky;
  logic rsp_last;

  //////////////////////////////
  // Read data path
  //////////////////////////////

  // Init completion word never shows up on R
  assign rvalid        = bnk_rd_valid & init_done;
  assign bnk_rd_accept = rready;
  assign rdata         = bnk_rd_data.data;
  assign rlast         = bnk_rd_data.last;
  assign rid           = bnk_rd_data.id;

  // Errors win over exclusive status
  always_comb
  begin
    if (bnk_rd_data.dbe || bnk_rd_data.err)
      rresp = axi2bnk_pkg::SLVERR;
    else if (bnk_rd_data.excl_ok)
      rresp = axi2bnk_pkg::EXOKAY;
    else
      rresp = axi2bnk_pkg::OKAY;
  end

  //////////////////////////////
  // Write response path
  //////////////////////////////

  assign rsp_last = bnk_rsp_data.last;

  // Non-last words are swallowed right away
  assign bvalid         = bnk_rsp_valid & rsp_last;
  assign bnk_rsp_accept = bnk_rsp_valid & (~rsp_last | bready);
  assign bid            = bnk_rsp_data.id;

  always_comb
  begin
    if (wr_err_sticky || bnk_rsp_data.err)
      bresp = axi2bnk_pkg::SLVERR;
    else if (bnk_rsp_data.excl_ok)
      bresp = axi2bnk_pkg::EXOKAY;
    else
      bresp = axi2bnk_pkg::OKAY;
  end

  // Error from any earlier beat of the burst, e.g. an RMW ECC failure
  always_ff @(posedge axi_clk or posedge rst_a)
  begin : wr_err_proc
    if (rst_a)
    begin
      wr_err_sticky <= 1'b0;
    end
    else if (bnk_rsp_valid && rsp_last && bready)
    begin
      wr_err_sticky <= 1'b0;
    end
    else if (bnk_rsp_valid && !rsp_last && bnk_rsp_data.err)
    begin
      wr_err_sticky <= 1'b1;
    end
  end

endmodule

/* design/axi2bnk_top.sv */
`timescale 1ns/1ps
`include "axi2bnk_consts.svh"

module axi2bnk_top
(
  input  logic                       axi_arvalid,
  output logic                       axi_arready,
  input  logic [`AXI2BNK_ID_W-1:0]   axi_arid,
  input  logic [`AXI2BNK_ADDR_W-1:0] axi_araddr,
  input  logic [`AXI2BNK_LEN_W-1:0]  axi_arlen,
  input  logic [`AXI2BNK_SIZE_W-1:0] axi_arsize,
  input  logic [1:0]                 axi_arburst,
  input  logic                       axi_arlock,
  input  logic                       axi_awvalid,
  output logic                       axi_awready,
  input  logic [`AXI2BNK_ID_W-1:0]   axi_awid,
  input  logic [`AXI2BNK_ADDR_W-1:0] axi_awaddr,
  input  logic [`AXI2BNK_LEN_W-1:0]  axi_awlen,
  input  logic [`AXI2BNK_SIZE_W-1:0] axi_awsize,
  input  logic [1:0]                 axi_awburst,
  input  logic                       axi_awlock,
  input  logic                       axi_wvalid,
  output logic                       axi_wready,
  input  logic [`AXI2BNK_DATA_W-1:0] axi_wdata,
  input  logic [`AXI2BNK_STRB_W-1:0] axi_wstrb,
  output logic                       axi_rvalid,
  input  logic                       axi_rready,
  output logic [`AXI2BNK_DATA_W-1:0] axi_rdata,
  output logic                       axi_rlast,
  output logic [1:0]                 axi_rresp,
  output logic [`AXI2BNK_ID_W-1:0]   axi_rid,
  output logic                       axi_bvalid,
  input  logic                       axi_bready,
  output logic [1:0]                 axi_bresp,
  output logic [`AXI2BNK_ID_W-1:0]   axi_bid,
  output logic                       bnk_rd_cmd_valid,
  output axi2bnk_pkg::bnk_cmd_t      bnk_rd_cmd_data,
  input  logic                       bnk_rd_cmd_accept,
  output logic                       bnk_wr_cmd_valid,
  output axi2bnk_pkg::bnk_cmd_t      bnk_wr_cmd_data,
  input  logic                       bnk_wr_cmd_accept,
  output logic                       bnk_wr_valid,
  output axi2bnk_pkg::bnk_wr_t       bnk_wr_data,
  input  logic                       bnk_wr_accept,
  input  logic                       bnk_rd_valid,
  input  axi2bnk_pkg::bnk_rd_t       bnk_rd_data,
  output logic                       bnk_rd_accept,
  input  logic                       bnk_rsp_valid,
  input  axi2bnk_pkg::bnk_wrsp_t     bnk_rsp_data,
  output logic                       bnk_rsp_accept,
  input  logic                       cmd_ecc_enable,
  input  logic                       init_start,
  input  logic                       disable_rst_init,
  output logic                       init_done,
  input  logic                       axi_clk,
  input  logic                       rst_a
);

  axi2bnk_pkg::axi_cmd_t ar_cmd;
  axi2bnk_pkg::axi_cmd_t aw_cmd;
  axi2bnk_pkg::axi_cmd_t ar_held_cmd;
  axi2bnk_pkg::axi_cmd_t aw_held_cmd;
  logic                  ar_held_valid;
  logic                  aw_held_valid;
  logic                  ar_bnk_accept;
  logic                  aw_bnk_accept;
  logic                  init_pending;

  //////////////////////////////
  // AXI address groups
  //////////////////////////////

  // ecc_en is filled in by the capture stage
  assign ar_cmd = '{id: axi_arid, addr: axi_araddr, len: axi_arlen, size: axi_arsize,
                    burst: axi2bnk_pkg::burst_e'(axi_arburst), lock: axi_arlock,
                    ecc_en: 1'b0};
  assign aw_cmd = '{id: axi_awid, addr: axi_awaddr, len: axi_awlen, size: axi_awsize,
                    burst: axi2bnk_pkg::burst_e'(axi_awburst), lock: axi_awlock,
                    ecc_en: 1'b0};

  cmd_capture ar_capture_i (
    .axi_clk    (axi_clk),
    .rst_a      (rst_a),
    .init_done  (init_done),
    .axi_valid  (axi_arvalid),
    .axi_ready  (axi_arready),
    .axi_cmd    (ar_cmd),
    .ecc_enable (cmd_ecc_enable),
    .held_valid (ar_held_valid),
    .held_cmd   (ar_held_cmd),
    .bnk_accept (ar_bnk_accept)
  );

  cmd_capture aw_capture_i (
    .axi_clk    (axi_clk),
    .rst_a      (rst_a),
    .init_done  (init_done),
    .axi_valid  (axi_awvalid),
    .axi_ready  (axi_awready),
    .axi_cmd    (aw_cmd),
    .ecc_enable (cmd_ecc_enable),
    .held_valid (aw_held_valid),
    .held_cmd   (aw_held_cmd),
    .bnk_accept (aw_bnk_accept)
  );

  cmd_encode cmd_encode_i (
    .rd_held_valid     (ar_held_valid),
    .rd_held_cmd       (ar_held_cmd),
    .rd_bnk_accept     (ar_bnk_accept),
    .wr_held_valid     (aw_held_valid),
    .wr_held_cmd       (aw_held_cmd),
    .wr_bnk_accept     (aw_bnk_accept),
    .init_pending      (init_pending),
    .bnk_rd_cmd_valid  (bnk_rd_cmd_valid),
    .bnk_rd_cmd_data   (bnk_rd_cmd_data),
    .bnk_rd_cmd_accept (bnk_rd_cmd_accept),
    .bnk_wr_cmd_valid  (bnk_wr_cmd_valid),
    .bnk_wr_cmd_data   (bnk_wr_cmd_data),
    .bnk_wr_cmd_accept (bnk_wr_cmd_accept)
  );

  init_ctrl init_ctrl_i (
    .axi_clk          (axi_clk),
    .rst_a            (rst_a),
    .disable_rst_init (disable_rst_init),
    .init_start       (init_start),
    .bnk_rd_valid     (bnk_rd_valid),
    .init_done        (init_done),
    .init_pending     (init_pending)
  );

  //////////////////////////////
  // Data and responses
  //////////////////////////////

  wdata_stage wdata_stage_i (
    .axi_clk       (axi_clk),
    .rst_a         (rst_a),
    .init_done     (init_done),
    .wvalid        (axi_wvalid),
    .wready        (axi_wready),
    .wdata         (axi_wdata),
    .wstrb         (axi_wstrb),
    .bnk_wr_valid  (bnk_wr_valid),
    .bnk_wr_data   (bnk_wr_data),
    .bnk_wr_accept (bnk_wr_accept)
  );

  bnk_resp_unpack bnk_resp_unpack_i (
    .axi_clk        (axi_clk),
    .rst_a          (rst_a),
    .init_done      (init_done),
    .bnk_rd_valid   (bnk_rd_valid),
    .bnk_rd_data    (bnk_rd_data),
    .bnk_rd_accept  (bnk_rd_accept),
    .rvalid         (axi_rvalid),
    .rready         (axi_rready),
    .rdata          (axi_rdata),
    .rlast          (axi_rlast),
    .rresp          (axi_rresp),
    .rid            (axi_rid),
    .bnk_rsp_valid  (bnk_rsp_valid),
    .bnk_rsp_data   (bnk_rsp_data),
    .bnk_rsp_accept (bnk_rsp_accept),
    .bvalid         (axi_bvalid),
    .bready         (axi_bready),
    .bresp          (axi_bresp),
    .bid            (axi_bid)
  );

endmodule

/* verif/axi2bnk_tb.sv */
`timescale 1ns/1ps
`include "axi2bnk_consts.svh"

module axi2bnk_tb;

  localparam int          CLK_HALF  = 10;
  localparam logic [31:0] LFSR_SEED = 32'h6323_4cde;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  // Transaction counts per test
  localparam int N_AR = 24;
  localparam int N_AW = 24;
  localparam int N_W  = 32;
  localparam int N_R  = 32;
  localparam int N_B  = 16;
  localparam int WATCHDOG_CYCLES = (N_AR + N_AW + N_W + N_R + N_B + 2) * 40;

  logic                       axi_clk = 1'b0;
  logic                       rst_a;
  logic                       axi_arvalid;
  logic                       axi_arready;
  logic [`AXI2BNK_ID_W-1:0]   axi_arid;
  logic [`AXI2BNK_ADDR_W-1:0] axi_araddr;
  logic [`AXI2BNK_LEN_W-1:0]  axi_arlen;
  logic [`AXI2BNK_SIZE_W-1:0] axi_arsize;
  logic [1:0]                 axi_arburst;
  logic                       axi_arlock;
  logic                       axi_awvalid;
  logic                       axi_awready;
  logic [`AXI2BNK_ID_W-1:0]   axi_awid;
  logic [`AXI2BNK_ADDR_W-1:0] axi_awaddr;
  logic [`AXI2BNK_LEN_W-1:0]  axi_awlen;
  logic [`AXI2BNK_SIZE_W-1:0] axi_awsize;
  logic [1:0]                 axi_awburst;
  logic                       axi_awlock;
  logic                       axi_wvalid;
  logic                       axi_wready;
  logic [`AXI2BNK_DATA_W-1:0] axi_wdata;
  logic [`AXI2BNK_STRB_W-1:0] axi_wstrb;
  logic                       axi_rvalid;
  logic                       axi_rready;
  logic [`AXI2BNK_DATA_W-1:0] axi_rdata;
  logic                       axi_rlast;
  logic [1:0]                 axi_rresp;
  logic [`AXI2BNK_ID_W-1:0]   axi_rid;
  logic                       axi_bvalid;
  logic                       axi_bready;
  logic [1:0]                 axi_bresp;
  logic [`AXI2BNK_ID_W-1:0]   axi_bid;
  logic                       bnk_rd_cmd_valid;
  axi2bnk_pkg::bnk_cmd_t      bnk_rd_cmd_data;
  logic                       bnk_rd_cmd_accept;
  logic                       bnk_wr_cmd_valid;
  axi2bnk_pkg::bnk_cmd_t      bnk_wr_cmd_data;
  logic                       bnk_wr_cmd_accept;
  logic                       bnk_wr_valid;
  axi2bnk_pkg::bnk_wr_t       bnk_wr_data;
  logic                       bnk_wr_accept;
  logic                       bnk_rd_valid;
  axi2bnk_pkg::bnk_rd_t       bnk_rd_data;
  logic                       bnk_rd_accept;
  logic                       bnk_rsp_valid;
  axi2bnk_pkg::bnk_wrsp_t     bnk_rsp_data;
  logic                       bnk_rsp_accept;
  logic                       cmd_ecc_enable;
  logic                       init_start;
  logic                       disable_rst_init;
  logic                       init_done;

  logic [31:0] lfsr = LFSR_SEED;
  int          err_count = 0;
  int          check_count = 0;
  int          tests_run = 0;

  axi2bnk_top axi2bnk_top_i (.*);

  always #(CLK_HALF) axi_clk = ~axi_clk;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Galois LFSR stepped once per bit taken
  function automatic logic [127:0] rand_bits(input int n);
    logic [127:0] val;
    int           i;
    val = '0;
    for (i = 0; i < n; i++)
    begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
      val  = {val[126:0], lfsr[0]};
    end
    return val;
  endfunction

  // Bank word expected for a command c = {lock, burst, size, len, addr, id}
  function automatic axi2bnk_pkg::bnk_cmd_t expect_cmd(
    input logic [49:0] c,
    input logic        ecc,
    input logic        rd
  );
    logic wrap_b;
    logic err_b;
    wrap_b = (c[48:47] == 2'b10);
    err_b  = (c[48:47] == 2'b00) || (c[48:47] == 2'b11);
    return {1'b0, c[3:0], ecc, err_b, c[35:4], c[43:36], c[46:44], wrap_b, rd, c[49]};
  endfunction

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    check_count++;
    if (got !== exp)
    begin
      $display("Mismatch %s: expected 0x%0h, got 0x%0h at %0t", name, exp, got, $time);
      err_count++;
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    check_count++;
    if (!cond)
    begin
      $display("Error at %0t: %s", $time, what);
      err_count++;
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (err_count == errs_before)
      $display("Test %s finished with no errors", name);
    else
      $display("Test %s finished with %0d errors", name, err_count - errs_before);
  endtask

  // Idle all valids and accepts driven by the testbench
  task automatic drop_valids();
    @(posedge axi_clk);
    #2;
    axi_arvalid       = 1'b0;
    axi_awvalid       = 1'b0;
    axi_wvalid        = 1'b0;
    axi_rready        = 1'b0;
    axi_bready        = 1'b0;
    bnk_rd_cmd_accept = 1'b0;
    bnk_wr_cmd_accept = 1'b0;
    bnk_wr_accept     = 1'b0;
    bnk_rd_valid      = 1'b0;
    bnk_rsp_valid     = 1'b0;
  endtask

  task automatic drive_cmd(input bit is_read, input logic valid, input logic [49:0] c);
    if (is_read)
    begin
      axi_arvalid = valid;
      axi_arid    = c[3:0];
      axi_araddr  = c[35:4];
      axi_arlen   = c[43:36];
      axi_arsize  = c[46:44];
      axi_arburst = c[48:47];
      axi_arlock  = c[49];
    end
    else
    begin
      axi_awvalid = valid;
      axi_awid    = c[3:0];
      axi_awaddr  = c[35:4];
      axi_awlen   = c[43:36];
      axi_awsize  = c[46:44];
      axi_awburst = c[48:47];
      axi_awlock  = c[49];
    end
  endtask

  //////////////////////////////
  // Bank init
  //////////////////////////////

  // Wait for the init word and answer it with one bank read word
  task automatic init_sequence(input string tag);
    int cyc;
    bit seen;
    seen = 1'b0;
    cyc  = 0;
    while (!seen && cyc < 20)
    begin
      @(negedge axi_clk);
      cyc++;
      check_value("init_done", init_done, 1'b0);
      check_value("{axi_arready, axi_awready, axi_wready}",
                  {axi_arready, axi_awready, axi_wready}, 3'b000);
      if (bnk_wr_cmd_valid)
      begin
        seen = 1'b1;
        check_value("bnk_wr_cmd_data.init", bnk_wr_cmd_data.init, 1'b1);
        check_value("bnk_wr_cmd_data.addr", bnk_wr_cmd_data.addr, '0);
      end
    end
    check_true(seen, {tag, ": no init command on the bank write command channel"});
    @(posedge axi_clk);
    #2;
    bnk_wr_cmd_accept = 1'b1;
    bnk_rd_valid      = 1'b1;
    @(negedge axi_clk);
    check_value("axi_rvalid", axi_rvalid, 1'b0);
    @(posedge axi_clk);
    #2;
    bnk_wr_cmd_accept = 1'b0;
    bnk_rd_valid      = 1'b0;
    @(negedge axi_clk);
    cyc = 1;
    while (!init_done && cyc < 5)
    begin
      @(negedge axi_clk);
      cyc++;
    end
    check_true(init_done, {tag, ": init_done did not rise after the bank read word"});
    check_value("{axi_arready, axi_awready, axi_wready}",
                {axi_arready, axi_awready, axi_wready}, 3'b111);
  endtask

  task automatic init_test();
    int errs0;
    errs0 = err_count;
    rst_a = 1'b1;
    repeat (3) @(posedge axi_clk);
    @(negedge axi_clk);
    check_value("{axi_arready, axi_awready, axi_wready}",
                {axi_arready, axi_awready, axi_wready}, 3'b000);
    check_value("{bnk_rd_cmd_valid, bnk_wr_cmd_valid, bnk_wr_valid}",
                {bnk_rd_cmd_valid, bnk_wr_cmd_valid, bnk_wr_valid}, 3'b000);
    @(posedge axi_clk);
    #2;
    rst_a = 1'b0;
    init_sequence("reset init");
    // Rising init_start restarts the sequence
    @(posedge axi_clk);
    #2;
    init_start = 1'b1;
    @(posedge axi_clk);
    #2;
    init_start = 1'b0;
    init_sequence("init_start");
    end_test("bank init", errs0);
  endtask

  //////////////////////////////
  // Command, data, response tests
  //////////////////////////////

  task automatic cmd_test(input bit is_read, input int count);
    axi2bnk_pkg::bnk_cmd_t exp_q[$];
    axi2bnk_pkg::bnk_cmd_t got_word;
    logic [127:0]          r;
    logic [49:0]           c_bits;
    logic                  pend;
    logic                  hs;
    logic                  b_valid;
    logic                  b_accept;
    int                    sent;
    int                    got;
    int                    errs0;
    string                 name;
    errs0  = err_count;
    pend   = 1'b0;
    hs     = 1'b0;
    c_bits = '0;
    sent   = 0;
    got    = 0;
    name   = is_read ? "bnk_rd_cmd_data" : "bnk_wr_cmd_data";
    while (got < count)
    begin
      @(posedge axi_clk);
      #2;
      if (!pend || hs)
      begin
        pend = 1'b0;
        if (sent < count && rand_bits(1))
        begin
          r      = rand_bits(50);
          c_bits = r[49:0];
          pend   = 1'b1;
          sent++;
        end
      end
      drive_cmd(is_read, pend, c_bits);
      cmd_ecc_enable = rand_bits(1);
      if (is_read)
        bnk_rd_cmd_accept = rand_bits(1);
      else
        bnk_wr_cmd_accept = rand_bits(1);
      @(negedge axi_clk);
      b_valid  = is_read ? bnk_rd_cmd_valid : bnk_wr_cmd_valid;
      b_accept = is_read ? bnk_rd_cmd_accept : bnk_wr_cmd_accept;
      got_word = is_read ? bnk_rd_cmd_data : bnk_wr_cmd_data;
      if (b_valid && b_accept)
      begin
        if (exp_q.size() == 0)
          check_true(1'b0, {name, " carried a command that was never sent"});
        else
          check_value(name, got_word, exp_q.pop_front());
        got++;
      end
      hs = pend && (is_read ? axi_arready : axi_awready);
      if (hs)
        exp_q.push_back(expect_cmd(c_bits, cmd_ecc_enable, is_read));
    end
    drop_valids();
    end_test(is_read ? "AR to bank read command" : "AW to bank write command", errs0);
  endtask

  task automatic w_test(input int count);
    axi2bnk_pkg::bnk_wr_t exp_q[$];
    axi2bnk_pkg::bnk_wr_t beat;
    logic [127:0]         r;
    logic                 pend;
    logic                 hs;
    int                   sent;
    int                   got;
    int                   errs0;
    errs0 = err_count;
    pend  = 1'b0;
    hs    = 1'b0;
    beat  = '0;
    sent  = 0;
    got   = 0;
    while (got < count)
    begin
      @(posedge axi_clk);
      #2;
      if (!pend || hs)
      begin
        pend = 1'b0;
        if (sent < count && rand_bits(1))
        begin
          r    = rand_bits(72);
          beat = r[71:0];
          pend = 1'b1;
          sent++;
        end
      end
      axi_wvalid    = pend;
      axi_wdata     = beat.data;
      axi_wstrb     = beat.strb;
      bnk_wr_accept = rand_bits(1);
      @(negedge axi_clk);
      if (bnk_wr_valid && bnk_wr_accept)
      begin
        if (exp_q.size() == 0)
          check_true(1'b0, "bank write channel carried a beat that was never sent");
        else
          check_value("bnk_wr_data", bnk_wr_data, exp_q.pop_front());
        got++;
      end
      hs = pend && axi_wready;
      if (hs)
        exp_q.push_back(beat);
    end
    drop_valids();
    end_test("W to bank write data", errs0);
  endtask

  task automatic r_test(input int count);
    axi2bnk_pkg::bnk_rd_t word;
    logic [127:0]         r;
    logic [1:0]           exp_resp;
    logic                 pend;
    logic                 hs;
    int                   done;
    int                   errs0;
    errs0 = err_count;
    word  = '0;
    pend  = 1'b0;
    hs    = 1'b0;
    done  = 0;
    while (done < count)
    begin
      @(posedge axi_clk);
      #2;
      if (!pend || hs)
      begin
        pend = 1'b0;
        if (rand_bits(1))
        begin
          r    = rand_bits(73);
          word = r[72:0];
          pend = 1'b1;
        end
      end
      bnk_rd_valid = pend;
      bnk_rd_data  = word;
      axi_rready   = rand_bits(1);
      @(negedge axi_clk);
      check_value("axi_rvalid", axi_rvalid, pend);
      check_value("bnk_rd_accept", bnk_rd_accept, axi_rready);
      hs = pend && axi_rready;
      if (hs)
      begin
        // Errors take priority over exclusive status
        if (word.dbe || word.err)
          exp_resp = 2'b10;
        else if (word.excl_ok)
          exp_resp = 2'b01;
        else
          exp_resp = 2'b00;
        check_value("axi_rdata", axi_rdata, word.data);
        check_value("axi_rid", axi_rid, word.id);
        check_value("axi_rlast", axi_rlast, word.last);
        check_value("axi_rresp", axi_rresp, exp_resp);
        done++;
      end
    end
    drop_valids();
    end_test("bank read to R", errs0);
  endtask

  task automatic b_test(input int count);
    axi2bnk_pkg::bnk_wrsp_t word;
    logic [1:0]             exp_resp;
    logic                   pend;
    logic                   accepted;
    logic                   sticky;
    int                     beats_left;
    int                     done;
    int                     errs0;
    errs0      = err_count;
    word       = '0;
    pend       = 1'b0;
    accepted   = 1'b0;
    sticky     = 1'b0;
    beats_left = 0;
    done       = 0;
    while (done < count)
    begin
      @(posedge axi_clk);
      #2;
      if (!pend || accepted)
      begin
        pend = 1'b0;
        if (rand_bits(1))
        begin
          // New response sequence of one to four words
          if (beats_left == 0)
          begin
            beats_left = rand_bits(2) + 1;
            word.id    = rand_bits(4);
          end
          word.last    = (beats_left == 1);
          word.err     = (rand_bits(2) == 0);
          word.excl_ok = rand_bits(1);
          pend         = 1'b1;
        end
      end
      bnk_rsp_valid = pend;
      bnk_rsp_data  = word;
      axi_bready    = rand_bits(1);
      @(negedge axi_clk);
      check_value("axi_bvalid", axi_bvalid, pend && word.last);
      check_value("bnk_rsp_accept", bnk_rsp_accept, pend && (!word.last || axi_bready));
      accepted = pend && bnk_rsp_accept;
      if (accepted && !word.last)
        sticky = sticky | word.err;
      if (axi_bvalid && axi_bready)
      begin
        if (sticky || word.err)
          exp_resp = 2'b10;
        else if (word.excl_ok)
          exp_resp = 2'b01;
        else
          exp_resp = 2'b00;
        check_value("axi_bresp", axi_bresp, exp_resp);
        check_value("axi_bid", axi_bid, word.id);
        sticky = 1'b0;
        done++;
      end
      if (accepted)
        beats_left--;
    end
    drop_valids();
    end_test("bank write response to B", errs0);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial
  begin
    rst_a             = 1'b1;
    disable_rst_init  = 1'b0;
    init_start        = 1'b0;
    cmd_ecc_enable    = 1'b0;
    drive_cmd(1'b1, 1'b0, '0);
    drive_cmd(1'b0, 1'b0, '0);
    axi_wvalid        = 1'b0;
    axi_wdata         = '0;
    axi_wstrb         = '0;
    axi_rready        = 1'b0;
    axi_bready        = 1'b0;
    bnk_rd_cmd_accept = 1'b0;
    bnk_wr_cmd_accept = 1'b0;
    bnk_wr_accept     = 1'b0;
    bnk_rd_valid      = 1'b0;
    bnk_rd_data       = '0;
    bnk_rsp_valid     = 1'b0;
    bnk_rsp_data      = '0;
    init_test();
    cmd_test(1'b1, N_AR);
    cmd_test(1'b0, N_AW);
    w_test(N_W);
    r_test(N_R);
    b_test(N_B);
    $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, check_count, err_count);
    if (err_count == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

  initial
  begin : watchdog
    #(WATCHDOG_CYCLES * 2 * CLK_HALF);
    $display("Watchdog expired after %0d cycles before all tests finished", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* axi2bnk.f */
+incdir+design
design/axi2bnk_pkg.sv
design/cmd_capture.sv
design/cmd_encode.sv
design/init_ctrl.sv
design/wdata_stage.sv
design/bnk_resp_unpack.sv
design/axi2bnk_top.sv
verif/axi2bnk_tb.sv
